/* all.f */
core_pkg.sv
reg_file.sv
instr_fifo.sv
instr_decoder.sv
alu.sv
issue_stage.sv
writeback_unit.sv
exec_core.sv
tb_exec_core.sv

/* alu.sv */
// alu
// combinational arithmetic and logic for all defined opcodes
// immediate forms arrive with the immediate already on b

`timescale 1ns/100ps

module alu import core_pkg::*; (
	input  opcode_t     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] y
);

	logic [4:0] shamt;
	logic       lt;

	// shifts use the low five bits only
	assign shamt = b[4:0];
	assign lt    = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			// arithmetic
			OP_ADD,
			OP_ADDI: y = a + b;
			OP_SUB:  y = a - b;
			// logic, register and immediate forms share the gate
			OP_AND,
			OP_ANDI: y = a & b;
			OP_OR,
			OP_ORI:  y = a | b;
			OP_XOR,
			OP_XORI: y = a ^ b;
			// shifts, logical both ways
			OP_SLL:  y = a << shamt;
			OP_SRL:  y = a >> shamt;
			// signed compare
			OP_SLT:  y = {31'd0, lt};
			// immediate is pre-shifted by the decoder
			OP_LUI:  y = b;
			// undefined codes
			default: y = '0;
		endcase
	end

endmodule

/* core_pkg.sv */
// core_pkg
// shared types for the two-stage execution core
// opcodes, the two instruction views, decoded op and result records

package core_pkg;

	// ------------------------------------------------------------------
	// opcodes
	// ------------------------------------------------------------------

	// bit 3 clear selects the register-register class
	// values 13 to 15 are undefined and come back as errors
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SLT  = 4'd7,
		OP_ADDI = 4'd8,
		OP_ANDI = 4'd9,
		OP_ORI  = 4'd10,
		OP_XORI = 4'd11,
		OP_LUI  = 4'd12
	} opcode_t;

	typedef logic [4:0] reg_idx_t;

	// ------------------------------------------------------------------
	// instruction word, one word read two ways
	// ------------------------------------------------------------------

	// register-register view
	typedef struct packed {
		opcode_t     op;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [12:0] unused;
	} r_fmt_t;

	// register-immediate view, imm is sign extended except for lui
	typedef struct packed {
		opcode_t     op;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		logic [17:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// ------------------------------------------------------------------
	// records between stages
	// ------------------------------------------------------------------

	// decoder output toward the issue stage
	typedef struct packed {
		opcode_t     op;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [31:0] imm32;
		logic        use_imm;
		logic        illegal;
	} dec_op_t;

	// one record per instruction, slot and output port
	typedef struct packed {
		reg_idx_t    rd;
		logic [31:0] value;
		logic        err;
	} result_t;

endpackage

/* exec_core.sv */
// exec_core
// two-stage integer execution core, top level
// buffer, issue stage, register file and writeback unit

`timescale 1ns/100ps

module exec_core import core_pkg::*; #(
	parameter int FIFO_DEPTH  = 4,
	parameter int RES_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_valid,
	input  instr_t  in_instr,
	output logic    in_credit,
	output logic    res_valid,
	output result_t res,
	input  logic    res_credit
);

	// buffer to issue
	logic        fifo_empty;
	instr_t      fifo_head;
	logic        pop;
	// register file ports
	reg_idx_t    ra1;
	reg_idx_t    ra2;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic        we;
	reg_idx_t    wa;
	logic [31:0] wd;
	// issue to writeback
	logic        issue_valid;
	result_t     issue_res;
	logic        slot_free;
	logic        slot_valid;
	result_t     slot_res;

	instr_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.pop        (pop),
		.fifo_empty (fifo_empty),
		.fifo_head  (fifo_head)
	);

	issue_stage u_issue (
		.fifo_empty  (fifo_empty),
		.fifo_head   (fifo_head),
		.pop         (pop),
		.ra1         (ra1),
		.ra2         (ra2),
		.rd1         (rd1),
		.rd2         (rd2),
		.slot_free   (slot_free),
		.slot_valid  (slot_valid),
		.slot_res    (slot_res),
		.issue_valid (issue_valid),
		.issue_res   (issue_res)
	);

	reg_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (we),
		.wa    (wa),
		.wd    (wd),
		.ra1   (ra1),
		.ra2   (ra2),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	writeback_unit #(
		.RES_CREDITS (RES_CREDITS)
	) u_wb (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_res   (issue_res),
		.slot_free   (slot_free),
		.slot_valid  (slot_valid),
		.slot_res    (slot_res),
		.res_credit  (res_credit),
		.res_valid   (res_valid),
		.res         (res),
		.we          (we),
		.wa          (wa),
		.wd          (wd)
	);

endmodule

/* instr_decoder.sv */
// instr_decoder
// combinational decode of one instruction word
// picks the register or immediate view by opcode class

`timescale 1ns/100ps

module instr_decoder import core_pkg::*; (
	input  instr_t  instr,
	output dec_op_t dec
);

	logic is_imm;

	// bit 3 of the opcode splits the two classes
	assign is_imm = instr.r.op[3];

	always_comb begin
		dec = '0;
		// op, rd and rs1 sit at the same bits in both views
		dec.op  = instr.r.op;
		dec.rd  = instr.r.rd;
		dec.rs1 = instr.r.rs1;
		if (is_imm) begin
			// ----------------------------------------------------------
			// register-immediate view
			// ----------------------------------------------------------
			// second read port unused, parked on r0
			dec.rs2     = '0;
			dec.use_imm = 1'b1;
			if (instr.i.op == OP_LUI) begin
				// upper 18 bits, low 14 cleared
				dec.imm32 = {instr.i.imm, 14'd0};
			end else begin
				dec.imm32 = {{14{instr.i.imm[17]}}, instr.i.imm};
			end
		end else begin
			// ----------------------------------------------------------
			// register-register view
			// ----------------------------------------------------------
			dec.rs2     = instr.r.rs2;
			dec.use_imm = 1'b0;
			dec.imm32   = '0;
		end
		// everything above lui is unassigned
		dec.illegal = (instr.r.op > OP_LUI);
	end

endmodule

/* instr_fifo.sv */
// instr_fifo
// input buffer for instruction words, filled against sender credits
// returns one credit the cycle after each entry is popped

`timescale 1ns/100ps

module instr_fifo import core_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  instr_t in_instr,
	output logic   in_credit,
	input  logic   pop,
	output logic   fifo_empty,
	output instr_t fifo_head
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	instr_t          mem [FIFO_DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            full;
	logic            push;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		if (p == PW'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full       = (count == CW'(FIFO_DEPTH));
	assign fifo_empty = (count == '0);
	assign push       = in_valid && !full;
	assign fifo_head  = mem[rd_ptr];

	// ------------------------------------------------------------------
	// storage, payload only
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_instr;
	end

	// ------------------------------------------------------------------
	// pointers, count and credit return
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// count moves only when exactly one side fires
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// one credit pulse per popped entry, a cycle later
			in_credit <= pop;
		end
	end

	// sender holds at most FIFO_DEPTH credits in total
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !full);

endmodule

/* issue_stage.sv */
// issue_stage
// pops the buffer head, decodes it, reads operands with forwarding
// from the writeback slot, runs the alu and hands the result on

`timescale 1ns/100ps

module issue_stage import core_pkg::*; (
	input  logic        fifo_empty,
	input  instr_t      fifo_head,
	output logic        pop,
	output reg_idx_t    ra1,
	output reg_idx_t    ra2,
	input  logic [31:0] rd1,
	input  logic [31:0] rd2,
	input  logic        slot_free,
	input  logic        slot_valid,
	input  result_t     slot_res,
	output logic        issue_valid,
	output result_t     issue_res
);

	dec_op_t     dec;
	logic        fwd_ok;
	logic        fwd1;
	logic        fwd2;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_b;
	logic [31:0] alu_y;

	instr_decoder u_dec (
		.instr (fifo_head),
		.dec   (dec)
	);

	// ------------------------------------------------------------------
	// operand read and forwarding
	// ------------------------------------------------------------------
	assign ra1 = dec.rs1;
	assign ra2 = dec.rs2;

	// the slot is the only pending write
	// it lands in the rf on the same edge that this stage pops,
	// so the value is forwarded even while the slot drains
	assign fwd_ok = slot_valid && !slot_res.err && (slot_res.rd != '0);
	assign fwd1   = fwd_ok && (slot_res.rd == dec.rs1);
	assign fwd2   = fwd_ok && (slot_res.rd == dec.rs2);

	assign op1 = fwd1 ? slot_res.value : rd1;
	assign op2 = fwd2 ? slot_res.value : rd2;

	// immediate forms take b from the decoder
	assign alu_b = dec.use_imm ? dec.imm32 : op2;

	alu u_alu (
		.op (dec.op),
		.a  (op1),
		.b  (alu_b),
		.y  (alu_y)
	);

	// ------------------------------------------------------------------
	// hand-off to writeback
	// ------------------------------------------------------------------
	// pop, compute and load the slot on one edge
	assign pop         = !fifo_empty && slot_free;
	assign issue_valid = pop;

	always_comb begin
		issue_res.rd = dec.rd;
		if (dec.illegal) begin
			// error record, nothing gets written
			issue_res.value = '0;
			issue_res.err   = 1'b1;
		end else begin
			issue_res.value = alu_y;
			issue_res.err   = 1'b0;
		end
	end

endmodule

/* reg_file.sv */
// reg_file
// 32 x 32 register array, two combinational read ports, one write port
// register 0 is hard wired to zero

`timescale 1ns/100ps

module reg_file import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  reg_idx_t    wa,
	input  logic [31:0] wd,
	input  reg_idx_t    ra1,
	input  reg_idx_t    ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	// no storage behind r0
	logic [31:0] regs [1:31];

	// ------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// ------------------------------------------------------------------
	// read ports
	// ------------------------------------------------------------------
	// no same-cycle bypass here
	// the issue stage forwards from the writeback slot instead
	assign rd1 = (ra1 == '0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? 32'd0 : regs[ra2];

	// write address comes from the writeback slot payload
	// which has no reset, so check it is settled whenever it is used
	a_wa_known: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(wa));

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_exec_core \
	-Mdir obj_dir -o sim_exec_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* tb_exec_core.sv */
// tb_exec_core
// directed testbench for the two-stage execution core
// keeps a reference register array, queues expected results in order
// and compares every result record leaving the output port

`timescale 1ns/100ps

module tb_exec_core import core_pkg::*; ();

	localparam int FIFO_DEPTH  = 4;
	localparam int RES_CREDITS = 2;
	localparam int CLK_HALF    = 50;

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	instr_t  in_instr;
	logic    in_credit;
	logic    res_valid;
	result_t res;
	logic    res_credit;

	// reference state, r0 is never written
	logic [31:0] ref_regs [32];
	result_t     exp_q [$];

	int     errors;
	int     checked;
	int     sender_credits;
	int     credit_pulses;
	int     results_seen;
	int     owed;
	int     sent_total;
	int     cycles;
	logic   hold_credits;
	integer seed;

	exec_core #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// limit grows with every instruction sent
	always @(posedge clk) begin
		cycles++;
		if (cycles > 20 * sent_total + 500) begin
			$display("timeout: run stopped after %0d cycles with %0d results outstanding",
				cycles, exp_q.size());
			$display("errors: %0d, results checked: %0d", errors, checked);
			$display("TB FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_result();
		result_t exp;
		if (exp_q.size() == 0) begin
			$display("result at %0t arrived with no instruction outstanding", $time);
			errors++;
		end else begin
			exp = exp_q.pop_front();
			compare_value("res.rd", 32'(res.rd), 32'(exp.rd));
			compare_value("res.value", res.value, exp.value);
			compare_value("res.err", 32'(res.err), 32'(exp.err));
			checked++;
		end
	endtask

	// one falling edge: outputs are settled here, inputs change here
	task automatic tick();
		@(negedge clk);
		in_valid = 1'b0;
		// credits owed from earlier results go back first
		if (!hold_credits && owed > 0) begin
			res_credit = 1'b1;
			owed--;
		end else begin
			res_credit = 1'b0;
		end
		if (rst_n) begin
			if (in_credit === 1'b1) begin
				sender_credits++;
				credit_pulses++;
			end
			if (res_valid === 1'b1) begin
				check_result();
				results_seen++;
				owed++;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// reference model and stimulus
	// ------------------------------------------------------------------
	task automatic exec_model(input instr_t w, output result_t r);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		a      = ref_regs[w.r.rs1];
		b      = ref_regs[w.r.rs2];
		simm   = {{14{w.i.imm[17]}}, w.i.imm};
		r.rd   = w.r.rd;
		r.err  = 1'b0;
		case (w.r.op)
			OP_ADD:  r.value = a + b;
			OP_SUB:  r.value = a - b;
			OP_AND:  r.value = a & b;
			OP_OR:   r.value = a | b;
			OP_XOR:  r.value = a ^ b;
			OP_SLL:  r.value = a << b[4:0];
			OP_SRL:  r.value = a >> b[4:0];
			OP_SLT:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_ADDI: r.value = a + simm;
			OP_ANDI: r.value = a & simm;
			OP_ORI:  r.value = a | simm;
			OP_XORI: r.value = a ^ simm;
			OP_LUI:  r.value = 32'(w.i.imm) << 14;
			default: begin
				r.value = '0;
				r.err   = 1'b1;
			end
		endcase
		if (!r.err && r.rd != '0)
			ref_regs[r.rd] = r.value;
	endtask

	function automatic instr_t r_op(input opcode_t op, input int rd, input int rs1,
		input int rs2);
		instr_t w;
		w        = '0;
		w.r.op   = op;
		w.r.rd   = 5'(rd);
		w.r.rs1  = 5'(rs1);
		w.r.rs2  = 5'(rs2);
		return w;
	endfunction

	function automatic instr_t i_op(input opcode_t op, input int rd, input int rs1,
		input int imm);
		instr_t w;
		w        = '0;
		w.i.op   = op;
		w.i.rd   = 5'(rd);
		w.i.rs1  = 5'(rs1);
		w.i.imm  = 18'(imm);
		return w;
	endfunction

	// undefined codes have no enum value
	function automatic instr_t raw_op(input logic [3:0] code, input int rd, input int rs1);
		return instr_t'({code, 5'(rd), 5'(rs1), 18'd0});
	endfunction

	task automatic random_instr(output instr_t w);
		logic [3:0] code;
		int         rd;
		int         rs1;
		int         rs2;
		code = 4'({$random(seed)} % 13);
		rd   = $random(seed);
		rs1  = $random(seed);
		rs2  = $random(seed);
		if (code < 4'd8)
			w = r_op(opcode_t'(code), rd, rs1, rs2);
		else
			w = i_op(opcode_t'(code), rd, rs1, rs2);
	endtask

	task automatic send(input instr_t w);
		result_t r;
		while (sender_credits == 0)
			tick();
		in_valid = 1'b1;
		in_instr = w;
		sender_credits--;
		sent_total++;
		exec_model(w, r);
		exp_q.push_back(r);
		tick();
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || owed != 0)
			tick();
		repeat (2) tick();
	endtask

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	task automatic test_reset();
		rst_n = 1'b0;
		repeat (4) begin
			tick();
			compare_value("res_valid", 32'(res_valid), 32'd0);
			compare_value("in_credit", 32'(in_credit), 32'd0);
		end
		rst_n          = 1'b1;
		sender_credits = FIFO_DEPTH;
		repeat (3) begin
			tick();
			compare_value("res_valid", 32'(res_valid), 32'd0);
			compare_value("in_credit", 32'(in_credit), 32'd0);
		end
		// or of a register with itself shows its reset value
		send(r_op(OP_OR, 1, 1, 1));
		send(r_op(OP_OR, 5, 5, 5));
		send(r_op(OP_OR, 17, 17, 17));
		send(r_op(OP_OR, 31, 31, 31));
		wait_drain();
	endtask

	// back to back, each one reads the one before
	task automatic test_alu_forwarding();
		send(i_op(OP_ADDI, 1, 0, 5));
		send(r_op(OP_ADD, 2, 1, 1));
		send(r_op(OP_SUB, 3, 1, 2));
		send(r_op(OP_AND, 4, 3, 2));
		send(r_op(OP_OR, 5, 4, 3));
		send(r_op(OP_XOR, 6, 5, 2));
		send(r_op(OP_SLL, 7, 2, 1));
		send(r_op(OP_SRL, 8, 3, 1));
		send(r_op(OP_SLT, 9, 3, 1));
		send(r_op(OP_SLT, 10, 1, 3));
		send(i_op(OP_ADDI, 11, 3, -100));
		send(i_op(OP_ANDI, 12, 11, -16));
		send(i_op(OP_ORI, 13, 12, 'h1f0f));
		send(i_op(OP_XORI, 14, 13, -1));
		send(i_op(OP_LUI, 15, 0, 'h2abcd));
		send(i_op(OP_ADDI, 16, 15, 'h1234));
		send(r_op(OP_ADD, 17, 16, 16));
		send(r_op(OP_SRL, 18, 15, 16));
		wait_drain();
	endtask

	task automatic test_reg_zero();
		send(i_op(OP_ADDI, 0, 0, 123));
		send(r_op(OP_ADD, 19, 0, 0));
		send(i_op(OP_ORI, 0, 2, 7));
		send(r_op(OP_OR, 19, 0, 2));
		wait_drain();
	endtask

	task automatic test_undefined();
		send(raw_op(4'd13, 2, 1));
		send(r_op(OP_OR, 20, 2, 0));
		send(raw_op(4'd14, 5, 3));
		send(raw_op(4'd15, 5, 5));
		send(r_op(OP_ADD, 21, 5, 0));
		wait_drain();
	endtask

	task automatic test_backpressure();
		int seen0;
		int sent0;
		int idle;
		seen0        = results_seen;
		sent0        = sent_total;
		idle         = 0;
		hold_credits = 1'b1;
		// keep sending until the sender is starved for a while
		while (idle < 10) begin
			if (sender_credits > 0) begin
				send(i_op(OP_ADDI, 21, 21, 1));
				idle = 0;
			end else begin
				tick();
				idle++;
			end
		end
		compare_value("results while held", 32'(results_seen - seen0), 32'(RES_CREDITS));
		compare_value("instructions accepted", 32'(sent_total - sent0),
			32'(FIFO_DEPTH + 1 + RES_CREDITS));
		hold_credits = 1'b0;
		wait_drain();
	endtask

	task automatic test_random();
		instr_t w;
		int     pulses0;
		int     sent0;
		pulses0 = credit_pulses;
		sent0   = sent_total;
		for (int n = 0; n < 200; n++) begin
			random_instr(w);
			send(w);
		end
		wait_drain();
		compare_value("in_credit pulses", 32'(credit_pulses - pulses0), 32'(sent_total - sent0));
	endtask

	initial begin
		rst_n          = 1'b0;
		in_valid       = 1'b0;
		in_instr       = '0;
		res_credit     = 1'b0;
		hold_credits   = 1'b0;
		seed           = 73;
		errors         = 0;
		checked        = 0;
		sender_credits = 0;
		credit_pulses  = 0;
		results_seen   = 0;
		owed           = 0;
		sent_total     = 0;
		cycles         = 0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;

		test_reset();
		test_alu_forwarding();
		test_reg_zero();
		test_undefined();
		test_backpressure();
		test_random();

		$display("errors: %0d, results checked: %0d", errors, checked);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* writeback_unit.sv */
// writeback_unit
// one result slot plus the output credit counter
// emits each result when a credit exists and commits its rf write then

`timescale 1ns/100ps

module writeback_unit import core_pkg::*; #(
	parameter int RES_CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_valid,
	input  result_t     issue_res,
	output logic        slot_free,
	output logic        slot_valid,
	output result_t     slot_res,
	input  logic        res_credit,
	output logic        res_valid,
	output result_t     res,
	output logic        we,
	output reg_idx_t    wa,
	output logic [31:0] wd
);

	localparam int CW = $clog2(RES_CREDITS + 1);

	logic [CW-1:0] credits;

	// ------------------------------------------------------------------
	// emission and slot status
	// ------------------------------------------------------------------
	assign res_valid = slot_valid && (credits != '0);
	assign res       = slot_res;
	// free when empty or when the held result leaves this edge
	assign slot_free = !slot_valid || res_valid;

	// commit the write with the emitted record, errors write nothing
	assign we = res_valid && !slot_res.err;
	assign wa = slot_res.rd;
	assign wd = slot_res.value;

	// ------------------------------------------------------------------
	// slot and credit state
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_valid <= 1'b0;
			credits    <= CW'(RES_CREDITS);
		end else begin
			// a load on the leaving edge keeps the slot full
			if (issue_valid)
				slot_valid <= 1'b1;
			else if (res_valid)
				slot_valid <= 1'b0;
			case ({res_valid, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (issue_valid)
			slot_res <= issue_res;
	end

	// issue only loads a slot that is free on this edge
	a_load_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> slot_free);

	// receiver never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		(res_credit && !res_valid) |-> (credits != CW'(RES_CREDITS)));

endmodule
